// ==== files.f ====
verilog/csi_rx_pkg.sv
verilog/csi_line_reset_gen.sv
verilog/csi_byte_aligner.sv
verilog/csi_lane_aligner.sv
verilog/csi_packet_decoder.sv
verilog/csi_raw10_depacker.sv
verilog/csi_rx_bridge.sv
verif/tb_clock_gen.sv
verif/tb_csi_rx_bridge.sv

// ==== Makefile ====
# Verilator build and run of the CSI-2 receive bridge testbench
VERILATOR ?= verilator
TOP       ?= tb_csi_rx_bridge
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_csi_rx_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csi_rx_bridge;
	import csi_rx_pkg::*;

	localparam int RESET_CYCLES   = 5;
	localparam int LP_CYCLES      = 6;   // lane-0 lp period ahead of each line
	localparam int LEAD_BYTES     = 2;   // idle hs bytes before the sync
	localparam int TAIL_BYTES     = 4;
	localparam int TEST_CYCLES    = 500; // rough total over five tests
	localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES;

	logic        clk;
	logic        reset;
	lane_bytes_t hs_data;
	logic        lp_data0;
	logic        lp_clk;
	pixel_pair_t pixels;
	logic        pixel_valid;
	logic        line_valid;
	logic        fsync;

	pixel_pair_t exp_q[$];            // pairs the dut still owes with the oldest first
	pixel_pair_t next_exp;
	int          cycle_count = 0;
	logic [31:0] rng_q       = 32'haaf3;
	string       test_name   = "reset";

	tb_clock_gen tb_clock_gen_i (
		.clk_o (clk)
	);

	csi_rx_bridge csi_rx_bridge_i (
		.clk_i         (clk),
		.reset_i       (reset),
		.hs_data_i     (hs_data),
		.lp_data0_i    (lp_data0),
		.lp_clk_i      (lp_clk),
		.pixels_o      (pixels),
		.pixel_valid_o (pixel_valid),
		.line_valid_o  (line_valid),
		.fsync_o       (fsync)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// byte m of a lane with off idle bits sent ahead of it lsb first
	function automatic byte_t lane_byte(input byte_t src[$], input int m, input int off);
		byte_t       cur;
		byte_t       prev;
		logic [15:0] win;
		cur  = (m >= 0 && m < src.size()) ? src[m] : 8'h00;
		prev = (m >= 1 && m <= src.size()) ? src[m-1] : 8'h00;
		win  = {cur, prev} << off;
		return win[15:8];
	endfunction

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: %s expected %0h, actual %0h",
				test_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("pixel_valid_o after reset", 32'd0, 32'(pixel_valid));
		check_value("line_valid_o after reset", 32'd0, 32'(line_valid));
		check_value("fsync_o after reset", 32'd0, 32'(fsync));
	endtask

	// lp period then one long packet split over both lanes
	task automatic send_line(input data_type_t dt, input int n_pix, input int off0,
			input int off1, input int lane1_lag);
		byte_t       pkt[$];
		byte_t       lane0[$];
		byte_t       lane1[$];
		pixel_t      grp[4];
		byte_t       lsbs;
		word_count_t wc;
		int          n_cycles;
		wc = word_count_t'(n_pix * 5 / 4); // 10 bits per pixel
		pkt.push_back({2'b00, dt});        // virtual channel 0
		pkt.push_back(wc[7:0]);
		pkt.push_back(wc[15:8]);
		pkt.push_back(8'h1D);              // ecc
		for (int g = 0; g < n_pix / 4; g++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				rng_q  = xorshift32(rng_q);
				grp[k] = rng_q[9:0];
				pkt.push_back(grp[k][9:2]);
				lsbs[2*k +: 2] = grp[k][1:0];
			end
			pkt.push_back(lsbs);
			if (dt == DT_RAW10)
			begin
				exp_q.push_back({grp[1], grp[0]}); // earlier pixel low
				exp_q.push_back({grp[3], grp[2]});
			end
		end
		pkt.push_back(8'h5A); // checksum
		pkt.push_back(8'hC3);
		lane0.push_back(SYNC_BYTE);
		lane1.push_back(SYNC_BYTE);
		for (int i = 0; i < pkt.size(); i++)
		begin
			if (i % 2 == 0)
				lane0.push_back(pkt[i]); // even bytes on lane 0
			else
				lane1.push_back(pkt[i]);
		end
		repeat (LP_CYCLES)
		begin
			@(posedge clk);
			lp_data0 <= 1'b1;
			lp_clk   <= 1'b0; // clock lane in hs
			hs_data  <= '0;
		end
		@(posedge clk);
		lp_data0 <= 1'b0;
		// one extra byte per lane carries the tail of the shifted stream
		n_cycles = LEAD_BYTES + lane1_lag + lane0.size() + 1 + TAIL_BYTES;
		for (int t = 0; t < n_cycles; t++)
		begin
			@(posedge clk);
			hs_data <= {lane_byte(lane1, t - LEAD_BYTES - lane1_lag, off1),
				lane_byte(lane0, t - LEAD_BYTES, off0)};
		end
	endtask

	task automatic wait_for_drain();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4)
		begin
			check_value("line_valid_o after the line", 32'd0, 32'(line_valid));
			@(negedge clk);
		end
	endtask

	task automatic test_raw10_line();
		test_name = "raw10_line";
		send_line(DT_RAW10, 40, 0, 0, 0);
		wait_for_drain();
	endtask

	task automatic test_wrong_data_type();
		test_name = "wrong_data_type";
		send_line(6'h2A, 40, 0, 0, 0); // raw8 that the decoder drops
		repeat (20)
		begin
			@(negedge clk);
			check_value("line_valid_o", 32'd0, 32'(line_valid));
		end
	endtask

	task automatic test_bit_offsets();
		test_name = "bit_offsets";
		send_line(DT_RAW10, 40, 3, 5, 1); // lane 1 a cycle behind
		wait_for_drain();
	endtask

	task automatic test_two_lines();
		test_name = "two_lines";
		send_line(DT_RAW10, 40, 1, 6, 0);
		wait_for_drain();
		send_line(DT_RAW10, 80, 7, 2, MAX_SKEW); // aligners must re-lock here
		wait_for_drain();
	endtask

	task automatic test_fsync();
		logic last_lp;
		test_name = "fsync";
		@(posedge clk);
		lp_clk <= 1'b0;
		apply_reset();
		@(posedge clk);
		check_value("fsync_o", 32'd0, 32'(fsync));
		last_lp = lp_clk;
		for (int i = 0; i < 32; i++)
		begin
			@(posedge clk);
			check_value("fsync_o", 32'(!last_lp), 32'(fsync)); // one cycle behind
			last_lp = lp_clk;
			rng_q   = xorshift32(rng_q);
			lp_clk <= rng_q[0];
		end
		@(posedge clk);
		lp_clk <= 1'b1;
	endtask

	// scoreboard on the pixel stream
	always @(posedge clk)
	begin
		if (pixel_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("pixel_valid_o went high with no pixel pair expected in %s",
					test_name);
				abort_run();
			end
			else
			begin
				next_exp = exp_q.pop_front();
				check_value("pixels_o", 32'(next_exp), 32'(pixels));
				check_value("line_valid_o during pixels", 32'd1, 32'(line_valid));
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles in %s", cycle_count, test_name);
			abort_run();
		end
	end

	initial
	begin
		reset    = 1'b1;
		hs_data  = '0;
		lp_data0 = 1'b1; // lanes idle in lp
		lp_clk   = 1'b1;
		apply_reset();
		test_raw10_line();
		test_wrong_data_type();
		test_bit_offsets();
		test_two_lines();
		test_fsync();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o
);
	localparam realtime HALF_PERIOD = 20.0; // 40 ns byte clock

	initial
	begin
		clk_o = 1'b0;
		forever
			#(HALF_PERIOD) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// ==== verilog/csi_rx_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi_rx_bridge (
	input  logic                    clk_i,        // byte clock from the phy
	input  logic                    reset_i,
	input  csi_rx_pkg::lane_bytes_t hs_data_i,    // deserialized hs bytes, lane 0 low
	input  logic                    lp_data0_i,
	input  logic                    lp_clk_i,
	output csi_rx_pkg::pixel_pair_t pixels_o,
	output logic                    pixel_valid_o,
	output logic                    line_valid_o,
	output logic                    fsync_o
);
	import csi_rx_pkg::*;

	logic             line_reset;
	logic             core_reset;    // global or per-line reset
	lane_bytes_t      byte_aligned;
	logic [LANES-1:0] byte_valid;
	lane_bytes_t      lane_aligned;
	logic             lane_valid;
	lane_bytes_t      payload;
	logic             payload_valid;

	csi_line_reset_gen csi_line_reset_gen_i (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.lp_data0_i   (lp_data0_i),
		.line_reset_o (line_reset)
	);

	assign core_reset = reset_i || line_reset;

	// one aligner per lane
	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		csi_byte_aligner csi_byte_aligner_i (
			.clk_i        (clk_i),
			.reset_i      (core_reset),
			.byte_i       (hs_data_i[8*i +: 8]),
			.byte_o       (byte_aligned[8*i +: 8]),
			.byte_valid_o (byte_valid[i])
		);
	end

	csi_lane_aligner csi_lane_aligner_i (
		.clk_i         (clk_i),
		.reset_i       (core_reset),
		.bytes_valid_i (byte_valid),
		.bytes_i       (byte_aligned),
		.lane_bytes_o  (lane_aligned),
		.lane_valid_o  (lane_valid)
	);

	csi_packet_decoder csi_packet_decoder_i (
		.clk_i           (clk_i),
		.reset_i         (core_reset),
		.data_valid_i    (lane_valid),
		.data_i          (lane_aligned),
		.payload_o       (payload),
		.payload_valid_o (payload_valid)
	);

	csi_raw10_depacker csi_raw10_depacker_i (
		.clk_i         (clk_i),
		.reset_i       (core_reset),
		.data_valid_i  (payload_valid),
		.data_i        (payload),
		.pixels_o      (pixels_o),
		.pixel_valid_o (pixel_valid_o),
		.line_valid_o  (line_valid_o)
	);

	// clock lane in hs means a frame is running
	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			fsync_o <= 1'b0;
		else
			fsync_o <= ~lp_clk_i;
	end

endmodule

`default_nettype wire

// ==== verilog/csi_raw10_depacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi_raw10_depacker (
	input  logic                    clk_i,
	input  logic                    reset_i,
	input  logic                    data_valid_i,
	input  csi_rx_pkg::lane_bytes_t data_i,
	output csi_rx_pkg::pixel_pair_t pixels_o,
	output logic                    pixel_valid_o,
	output logic                    line_valid_o
);
	import csi_rx_pkg::*;

	logic [2:0]  phase_q;  // beat within a ten-byte block, two groups
	byte_t       hi_q [4]; // high bytes of the group being gathered
	byte_t       lo_byte;
	byte_t       hi_byte;
	byte_t       lsb;      // fifth byte of a group
	byte_t       hi3;
	pixel_t      pix [4];
	logic        group_done;
	pixel_pair_t pair_q [2]; // queued pairs of the last group
	logic [1:0]  pend_q;     // pairs still to leave

	assign lo_byte = data_i[7:0];
	assign hi_byte = data_i[15:8];

	// groups close on beat 2 (lane 0 byte) and beat 4 (lane 1 byte)
	assign group_done = data_valid_i && (phase_q == 3'd2 || phase_q == 3'd4);
	assign lsb        = (phase_q == 3'd2) ? lo_byte : hi_byte;
	assign hi3        = (phase_q == 3'd4) ? lo_byte : hi_q[3]; // arrives with lsb

	always_comb
	begin
		for (int k = 0; k < 4; k++)
			pix[k] = {hi_q[k], lsb[2*k +: 2]};
		pix[3] = {hi3, lsb[7:6]};
	end

	always_ff @(posedge clk_i)
	begin
		if (data_valid_i)
		begin
			case (phase_q)
				3'd0:
				begin
					hi_q[0] <= lo_byte;
					hi_q[1] <= hi_byte;
				end
				3'd1:
				begin
					hi_q[2] <= lo_byte;
					hi_q[3] <= hi_byte;
				end
				3'd2: hi_q[0] <= hi_byte; // second group starts mid beat
				3'd3:
				begin
					hi_q[1] <= lo_byte;
					hi_q[2] <= hi_byte;
				end
				default: ; // beat 4 used in place
			endcase
		end
		if (group_done)
		begin
			pair_q[0] <= {pix[1], pix[0]};
			pair_q[1] <= {pix[3], pix[2]};
		end
		if (reset_i)
		begin
			phase_q <= '0;
			pend_q  <= '0;
		end
		else
		begin
			if (data_valid_i)
				phase_q <= (phase_q == 3'd4) ? 3'd0 : phase_q + 3'd1;
			// groups close at least two beats apart, so the queue has drained
			if (group_done)
				pend_q <= 2'd2;
			else if (pend_q != 2'd0)
				pend_q <= pend_q - 2'd1;
		end
	end

	assign pixels_o      = (pend_q == 2'd2) ? pair_q[0] : pair_q[1];
	assign pixel_valid_o = (pend_q != 2'd0);
	// high from first payload beat until the queue empties
	assign line_valid_o  = data_valid_i || pixel_valid_o || (phase_q != 3'd0);

endmodule

`default_nettype wire

// ==== verilog/csi_packet_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi_packet_decoder (
	input  logic                    clk_i,
	input  logic                    reset_i,
	input  logic                    data_valid_i,
	input  csi_rx_pkg::lane_bytes_t data_i,
	output csi_rx_pkg::lane_bytes_t payload_o,
	output logic                    payload_valid_o
);
	import csi_rx_pkg::*;

	typedef enum logic [1:0] {
		ST_HDR_FIRST,  // data id and word count low
		ST_HDR_SECOND, // word count high and ecc
		ST_PAYLOAD,
		ST_DROP        // wait here for the next reset
	} state_t;

	state_t      state_q;
	data_type_t  dt_q;      // data type of the current packet
	byte_t       wc_lo_q;   // word count low byte from beat 0
	word_count_t remain_q;  // payload bytes still to pass
	word_count_t wc_full;

	// beat 1 carries the word count high byte on lane 0
	assign wc_full = {data_i[7:0], wc_lo_q};

	always_ff @(posedge clk_i)
	begin
		payload_o <= data_i;
		if (data_valid_i && state_q == ST_HDR_FIRST)
		begin
			dt_q    <= data_i[5:0]; // virtual channel bits dropped
			wc_lo_q <= data_i[15:8];
		end
		if (reset_i)
		begin
			state_q         <= ST_HDR_FIRST;
			remain_q        <= '0;
			payload_valid_o <= 1'b0;
		end
		else
		begin
			payload_valid_o <= 1'b0;
			if (data_valid_i)
			begin
				case (state_q)
					ST_HDR_FIRST:
					begin
						state_q <= ST_HDR_SECOND;
					end
					ST_HDR_SECOND:
					begin
						// ecc byte on lane 1 not checked
						remain_q <= wc_full;
						if (dt_q == DT_RAW10 && wc_full != '0)
							state_q <= ST_PAYLOAD;
						else
							state_q <= ST_DROP; // short or non-raw10 packet
					end
					ST_PAYLOAD:
					begin
						payload_valid_o <= 1'b1;
						remain_q        <= remain_q - word_count_t'(LANES);
						if (remain_q <= word_count_t'(LANES))
							state_q <= ST_DROP; // checksum follows, ignored
					end
					default:
					begin
						state_q <= ST_DROP;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/csi_lane_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi_lane_aligner (
	input  logic                         clk_i,
	input  logic                         reset_i,
	input  logic [csi_rx_pkg::LANES-1:0] bytes_valid_i,
	input  csi_rx_pkg::lane_bytes_t      bytes_i,
	output csi_rx_pkg::lane_bytes_t      lane_bytes_o,
	output logic                         lane_valid_o
);
	import csi_rx_pkg::*;

	localparam int DLY_W = $clog2(MAX_SKEW + 1);

	byte_t               bhist_q [LANES][MAX_SKEW]; // past bytes, index 0 newest
	logic [MAX_SKEW-1:0] vhist_q [LANES];           // past valids, bit 0 newest
	logic [DLY_W-1:0]    delay_q [LANES];           // delay frozen at first alignment
	logic [DLY_W-1:0]    delay   [LANES];
	logic                locked_q;
	logic                all_valid;
	lane_bytes_t         tap;

	assign all_valid = &bytes_valid_i;

	always_comb
	begin
		for (int l = 0; l < LANES; l++)
		begin
			// earlier valid cycles tell how far ahead this lane ran
			delay[l] = '0;
			for (int d = 0; d < MAX_SKEW; d++)
				delay[l] = delay[l] + DLY_W'(vhist_q[l][d]);
			if (locked_q)
				delay[l] = delay_q[l];
			tap[l*8 +: 8] = bytes_i[l*8 +: 8]; // zero delay, latest lane
			for (int d = 0; d < MAX_SKEW; d++)
				if (delay[l] == DLY_W'(d + 1))
					tap[l*8 +: 8] = bhist_q[l][d];
		end
	end

	always_ff @(posedge clk_i)
	begin
		lane_bytes_o <= tap;
		for (int l = 0; l < LANES; l++)
		begin
			bhist_q[l][0] <= bytes_i[l*8 +: 8];
			for (int d = 1; d < MAX_SKEW; d++)
				bhist_q[l][d] <= bhist_q[l][d-1];
		end
		if (reset_i)
		begin
			locked_q     <= 1'b0;
			lane_valid_o <= 1'b0;
			for (int l = 0; l < LANES; l++)
			begin
				vhist_q[l] <= '0;
				delay_q[l] <= '0;
			end
		end
		else
		begin
			lane_valid_o <= all_valid; // one cycle past the latest lane
			for (int l = 0; l < LANES; l++)
				vhist_q[l] <= (vhist_q[l] << 1) | MAX_SKEW'(bytes_valid_i[l]);
			if (all_valid && !locked_q)
			begin
				locked_q <= 1'b1;
				for (int l = 0; l < LANES; l++)
					delay_q[l] <= delay[l];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/csi_byte_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi_byte_aligner (
	input  logic              clk_i,
	input  logic              reset_i,
	input  csi_rx_pkg::byte_t byte_i,
	output csi_rx_pkg::byte_t byte_o,
	output logic              byte_valid_o
);
	import csi_rx_pkg::*;

	byte_t       prev_q;      // byte from the previous clock
	logic [15:0] window;      // current byte on top, previous below
	logic [2:0]  offset_q;    // locked bit offset of the sync
	logic        locked_q;
	logic        hit;
	logic [2:0]  hit_offset;

	// bits arrive lsb first, so older bits sit lower in the window
	assign window = {byte_i, prev_q};

	// scan all eight bit windows, lowest offset wins
	always_comb
	begin
		hit        = 1'b0;
		hit_offset = '0;
		for (int k = 7; k >= 0; k--)
		begin
			if (window[k +: 8] == SYNC_BYTE)
			begin
				hit        = 1'b1;
				hit_offset = 3'(k);
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		prev_q <= byte_i;
		byte_o <= window[offset_q +: 8]; // realigned byte
		if (reset_i)
		begin
			locked_q     <= 1'b0;
			offset_q     <= '0;
			byte_valid_o <= 1'b0;
		end
		else
		begin
			// valid from the first byte after the sync onward
			byte_valid_o <= locked_q;
			if (!locked_q && hit)
			begin
				locked_q <= 1'b1; // hold until next reset
				offset_q <= hit_offset;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/csi_line_reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi_line_reset_gen (
	input  logic clk_i,
	input  logic reset_i,
	input  logic lp_data0_i,    // low-power level of data lane 0
	output logic line_reset_o
);
	import csi_rx_pkg::*;

	localparam int CNT_W = $clog2(LP_DEBOUNCE + 1);

	logic [CNT_W-1:0] lp_cnt_q; // consecutive lp-high cycles, saturates

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			lp_cnt_q <= '0;
		else if (!lp_data0_i)
			lp_cnt_q <= '0; // any hs cycle restarts the count
		else if (lp_cnt_q != CNT_W'(LP_DEBOUNCE))
			lp_cnt_q <= lp_cnt_q + 1'b1;
	end

	// held while the lane stays in lp, drops the cycle after it leaves
	assign line_reset_o = (lp_cnt_q == CNT_W'(LP_DEBOUNCE));

endmodule

`default_nettype wire

// ==== verilog/csi_rx_pkg.sv ====
`default_nettype none

package csi_rx_pkg;

	// two data lanes at gear 8
	localparam int LANES = 2;

	// one deserialized byte from a single lane
	typedef logic [7:0] byte_t;

	// lane 0 sits in the low byte
	typedef logic [LANES*8-1:0] lane_bytes_t;

	// raw10 pixel and a pair of them, earlier pixel low
	typedef logic [9:0]  pixel_t;
	typedef logic [19:0] pixel_pair_t;

	// long packet header fields
	typedef logic [15:0] word_count_t; // payload length in bytes
	typedef logic [5:0]  data_type_t;

	// hs sync pattern, sent lsb first on each lane
	localparam byte_t SYNC_BYTE = 8'hB8;

	// only data type forwarded to the depacker
	localparam data_type_t DT_RAW10 = 6'h2B;

	// consecutive lp-high cycles on lane 0 before a line reset fires
	localparam int LP_DEBOUNCE = 4;

	// worst lane-to-lane skew the lane aligner can absorb, in byte clocks
	localparam int MAX_SKEW = 2;

endpackage

`default_nettype wire
